// File: hdl/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // field widths
    localparam int VPPN_W = 19;
    localparam int ASID_W = 10;
    localparam int PPN_W  = 20;
    localparam int PS_W   = 6;

    // lowest vppn bit still compared for a 2 MiB page,
    // the bit below it picks the odd half of the pair
    localparam int HUGE_TAG_LSB = 9;

    // page size as log2 of the page bytes
    typedef enum logic [PS_W-1:0] {
        PS_4K = 6'd12,
        PS_2M = 6'd21
    } tlb_ps_e;

    // one physical page of a pair
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    // even page in page0, odd page in page1
    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_ps_e           ps;
        logic              e;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              odd_page;
    } tlb_query_t;

    typedef struct packed {
        logic      found;
        tlb_ps_e   ps;
        tlb_page_t page;
    } tlb_result_t;

endpackage

`default_nettype wire

// File: hdl/tlb_storage.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_storage #(
    parameter int tlbnum = 32
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // write port
    input  wire logic                               we,
    input  wire logic [$clog2(tlbnum)-1:0]          w_index,
    input  wire tlb_pkg::tlb_entry_t                w_entry,

    // read port
    input  wire logic [$clog2(tlbnum)-1:0]          r_index,
    output tlb_pkg::tlb_entry_t                     r_entry,

    // whole table, seen by every search port
    output tlb_pkg::tlb_entry_t                     entries [tlbnum]
);

    localparam int IDX_W = $clog2(tlbnum);

    tlb_pkg::tlb_entry_t mem [tlbnum];

    // exist bits cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < tlbnum; i++) begin
                mem[i].e <= 1'b0;
            end
        end else if (we) begin
            mem[w_index] <= w_entry;
        end
    end

    assign entries = mem;

    // combinational read, no bypass of a write in the same cycle
    assign r_entry = mem[r_index];

    // index beyond the table would be lost silently
    a_write_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> (w_index < IDX_W'(tlbnum - 1) || w_index == IDX_W'(tlbnum - 1))
    ) else $error("tlb write index %0d out of range", w_index);

endmodule

`default_nettype wire

// File: hdl/tlb_search.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_search #(
    parameter int tlbnum = 32
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // search request
    input  wire logic                               valid,
    input  wire tlb_pkg::tlb_query_t                query,

    // table contents
    input  wire tlb_pkg::tlb_entry_t                entries [tlbnum],

    // search response, one cycle after valid
    output tlb_pkg::tlb_result_t                    result,
    output logic [$clog2(tlbnum)-1:0]               index
);

    localparam int IDX_W  = $clog2(tlbnum);
    localparam int PAGE_W = $bits(tlb_pkg::tlb_page_t);
    localparam int PICK_W = tlb_pkg::PS_W + PAGE_W;

    // compare stage
    logic [tlbnum-1:0] hit_d;
    logic [tlbnum-1:0] odd_d;

    // registered match
    logic [tlbnum-1:0] match_q;
    logic [tlbnum-1:0] odd_q;

    // per entry ps and chosen page, zero unless that entry hit
    logic [PICK_W-1:0] pick [tlbnum];

    logic [PICK_W-1:0] pick_or;
    logic [IDX_W-1:0]  idx_or;

    for (genvar i = 0; i < tlbnum; i++) begin : g_entry
        logic                is_4k;
        logic                asid_ok;
        logic                tag_ok;
        tlb_pkg::tlb_page_t  sel_page;

        assign is_4k   = (entries[i].ps == tlb_pkg::PS_4K);
        assign asid_ok = entries[i].g || (entries[i].asid == query.asid);

        // a 2 MiB page ignores the low vppn bits
        assign tag_ok = is_4k
            ? (entries[i].vppn == query.vppn)
            : (entries[i].vppn[tlb_pkg::VPPN_W-1:tlb_pkg::HUGE_TAG_LSB] ==
               query.vppn[tlb_pkg::VPPN_W-1:tlb_pkg::HUGE_TAG_LSB]);

        assign hit_d[i] = entries[i].e && asid_ok && tag_ok;

        // odd half comes from the query for 4 KiB, from vppn bit 8 otherwise
        assign odd_d[i] = is_4k ? query.odd_page
                                : query.vppn[tlb_pkg::HUGE_TAG_LSB-1];

        // payload follows the entry's current contents
        assign sel_page = odd_q[i] ? entries[i].page1 : entries[i].page0;
        assign pick[i]  = match_q[i] ? {entries[i].ps, sel_page} : '0;
    end

    // hold the last search until the next valid one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_q <= '0;
            odd_q   <= '0;
        end else if (valid) begin
            match_q <= hit_d;
            odd_q   <= odd_d;
        end
    end

    // and-or mux, hits are unique so no priority is needed
    always_comb begin
        pick_or = '0;
        idx_or  = '0;
        for (int i = 0; i < tlbnum; i++) begin
            pick_or = pick_or | pick[i];
            if (match_q[i]) begin
                idx_or = idx_or | IDX_W'(i);
            end
        end
    end

    assign result.found = |match_q;
    assign result.ps    = tlb_pkg::tlb_ps_e'(pick_or[PICK_W-1 -: tlb_pkg::PS_W]);
    assign result.page  = pick_or[PAGE_W-1:0];
    assign index        = idx_or;

    // two live entries on one tag means the table was loaded wrongly
    a_match_unique: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(match_q)
    ) else $error("tlb multiple hit, match vector %h", match_q);

endmodule

`default_nettype wire

// File: hdl/tlb.sv
`timescale 1ns/100ps
`default_nettype none

module tlb #(
    parameter int tlbnum = 32
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // search port 0
    input  wire logic                               s0_valid,
    input  wire tlb_pkg::tlb_query_t                s0_query,
    output tlb_pkg::tlb_result_t                    s0_result,
    output logic [$clog2(tlbnum)-1:0]               s0_index,

    // search port 1
    input  wire logic                               s1_valid,
    input  wire tlb_pkg::tlb_query_t                s1_query,
    output tlb_pkg::tlb_result_t                    s1_result,
    output logic [$clog2(tlbnum)-1:0]               s1_index,

    // write port
    input  wire logic                               we,
    input  wire logic [$clog2(tlbnum)-1:0]          w_index,
    input  wire tlb_pkg::tlb_entry_t                w_entry,

    // read port
    input  wire logic [$clog2(tlbnum)-1:0]          r_index,
    output tlb_pkg::tlb_entry_t                     r_entry
);

    // shared table
    tlb_pkg::tlb_entry_t entries [tlbnum];

    tlb_storage #(
        .tlbnum  (tlbnum)
    ) u_storage (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // instruction side, typically
    tlb_search #(
        .tlbnum  (tlbnum)
    ) u_search0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (s0_valid),
        .query   (s0_query),
        .entries (entries),
        .result  (s0_result),
        .index   (s0_index)
    );

    // data side
    tlb_search #(
        .tlbnum  (tlbnum)
    ) u_search1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (s1_valid),
        .query   (s1_query),
        .entries (entries),
        .result  (s1_result),
        .index   (s1_index)
    );

endmodule

`default_nettype wire

// File: tb/tlb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_checker #(
    parameter int tlbnum = 32
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        s0_valid,
    input  wire tlb_pkg::tlb_query_t         s0_query,
    input  wire tlb_pkg::tlb_result_t        s0_result,
    input  wire logic [$clog2(tlbnum)-1:0]   s0_index,
    input  wire logic                        s1_valid,
    input  wire tlb_pkg::tlb_query_t         s1_query,
    input  wire tlb_pkg::tlb_result_t        s1_result,
    input  wire logic [$clog2(tlbnum)-1:0]   s1_index,
    input  wire logic                        we,
    input  wire logic [$clog2(tlbnum)-1:0]   w_index,
    input  wire tlb_pkg::tlb_entry_t         w_entry,
    input  wire logic [$clog2(tlbnum)-1:0]   r_index,
    input  wire tlb_pkg::tlb_entry_t         r_entry,
    output int                               errors,
    output int                               checks,
    output logic                             pending
);

    localparam int IDX_W = $clog2(tlbnum);
    localparam int LSB   = tlb_pkg::HUGE_TAG_LSB;

    // what a port keeps from its last valid search
    typedef struct packed {
        logic             found;
        logic             odd;
        logic [IDX_W-1:0] idx;
    } hold_t;

    tlb_pkg::tlb_entry_t model [tlbnum];
    logic [tlbnum-1:0]   written;
    hold_t               hold0;
    hold_t               hold1;
    int                  err_count = 0;
    int                  check_count = 0;

    assign errors = err_count;
    assign checks = check_count;

    function automatic hold_t predict_search(input tlb_pkg::tlb_query_t q);
        hold_t h;
        logic  tag_ok;
        h = '0;
        for (int i = 0; i < tlbnum; i++) begin
            if (model[i].ps == tlb_pkg::PS_4K) begin
                tag_ok = (model[i].vppn == q.vppn);
            end else begin
                tag_ok = ((model[i].vppn >> LSB) == (q.vppn >> LSB));
            end
            if (model[i].e && (model[i].g || model[i].asid == q.asid) && tag_ok) begin
                h.found = 1'b1;
                h.idx   = IDX_W'(i);
                // huge pages split the pair on vppn bit 8
                h.odd   = (model[i].ps == tlb_pkg::PS_4K) ? q.odd_page : q.vppn[LSB-1];
            end
        end
        return h;
    endfunction

    // payload comes from whatever the hit entry holds now
    function automatic tlb_pkg::tlb_result_t expected_result(input hold_t h);
        tlb_pkg::tlb_result_t r;
        r = '0;
        if (h.found) begin
            r.found = 1'b1;
            r.ps    = model[h.idx].ps;
            r.page  = h.odd ? model[h.idx].page1 : model[h.idx].page0;
        end
        return r;
    endfunction

    task automatic compare_search(input string name, input hold_t h,
                                  input tlb_pkg::tlb_result_t got,
                                  input logic [IDX_W-1:0] got_idx);
        tlb_pkg::tlb_result_t exp;
        exp = expected_result(h);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH %s_result got %h exp %h", name, got, exp);
        end
        if (got_idx !== h.idx) begin
            err_count++;
            $display("MISMATCH %s_index got %h exp %h", name, got_idx, h.idx);
        end
    endtask

    task automatic check_read_port();
        check_count++;
        if (written[r_index]) begin
            if (r_entry !== model[r_index]) begin
                err_count++;
                $display("MISMATCH r_entry got %h exp %h", r_entry, model[r_index]);
            end
        end else if (r_entry.e !== 1'b0) begin
            err_count++;
            $display("MISMATCH r_entry.e got %h exp %h", r_entry.e, 1'b0);
        end
    endtask

    // outputs are sampled before this edge updates anything
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < tlbnum; i++) begin
                model[i].e <= 1'b0;
            end
            written <= '0;
            hold0   <= '0;
            hold1   <= '0;
            pending <= 1'b0;
        end else begin
            compare_search("s0", hold0, s0_result, s0_index);
            compare_search("s1", hold1, s1_result, s1_index);
            check_read_port();
            if (s0_valid) begin
                hold0 <= predict_search(s0_query);
            end
            if (s1_valid) begin
                hold1 <= predict_search(s1_query);
            end
            if (we) begin
                model[w_index]   <= w_entry;
                written[w_index] <= 1'b1;
            end
            pending <= s0_valid || s1_valid;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_tlb.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tlb;

    localparam int TLBNUM  = 32;
    localparam int IDX_W   = $clog2(TLBNUM);
    localparam int VPPN_W  = tlb_pkg::VPPN_W;
    localparam int ASID_W  = tlb_pkg::ASID_W;
    localparam int LOW_W   = tlb_pkg::HUGE_TAG_LSB;
    localparam int TOP_W   = VPPN_W - LOW_W;
    localparam int PAGE_W  = $bits(tlb_pkg::tlb_page_t);
    localparam int QUERY_W = $bits(tlb_pkg::tlb_query_t);

    logic                 clk;
    logic                 rst_n;
    logic                 s0_valid;
    tlb_pkg::tlb_query_t  s0_query;
    tlb_pkg::tlb_result_t s0_result;
    logic [IDX_W-1:0]     s0_index;
    logic                 s1_valid;
    tlb_pkg::tlb_query_t  s1_query;
    tlb_pkg::tlb_result_t s1_result;
    logic [IDX_W-1:0]     s1_index;
    logic                 we;
    logic [IDX_W-1:0]     w_index;
    tlb_pkg::tlb_entry_t  w_entry;
    logic [IDX_W-1:0]     r_index;
    tlb_pkg::tlb_entry_t  r_entry;

    int                   chk_errors;
    int                   chk_checks;
    logic                 chk_pending;
    int                   tb_errors;
    int                   wait_cycles;
    logic [TOP_W-1:0]     tag_base;
    logic [VPPN_W-1:0]    vppn_of [TLBNUM];
    logic [ASID_W-1:0]    asid_of [TLBNUM];

    always #20 clk = ~clk;

    tlb #(.tlbnum(TLBNUM)) dut (.*);

    tlb_checker #(.tlbnum(TLBNUM)) u_check (
        .*,
        .errors  (chk_errors),
        .checks  (chk_checks),
        .pending (chk_pending)
    );

    function automatic tlb_pkg::tlb_entry_t new_entry(input int idx);
        tlb_pkg::tlb_entry_t ent;
        // upper tag bits differ per index, so two entries never hit together
        ent.vppn  = {tag_base + TOP_W'(idx), LOW_W'($urandom)};
        ent.asid  = ASID_W'($urandom);
        ent.g     = ($urandom_range(3) == 0);
        ent.ps    = ($urandom_range(1) == 1) ? tlb_pkg::PS_2M : tlb_pkg::PS_4K;
        ent.e     = ($urandom_range(4) != 0);
        ent.page0 = PAGE_W'($urandom);
        ent.page1 = PAGE_W'($urandom);
        return ent;
    endfunction

    function automatic tlb_pkg::tlb_query_t pick_query();
        tlb_pkg::tlb_query_t q;
        int k;
        q = QUERY_W'($urandom);
        if ($urandom_range(1) == 1) begin
            k = $urandom_range(TLBNUM - 1);
            q.vppn = vppn_of[k];
            if ($urandom_range(1) == 1) begin
                q.asid = asid_of[k];
            end
            // new low bits, still a hit on a 2 MiB page
            if ($urandom_range(3) == 0) begin
                q.vppn[LOW_W-1:0] = LOW_W'($urandom);
            end
        end
        return q;
    endfunction

    task automatic drive_write(input int idx);
        tlb_pkg::tlb_entry_t ent;
        ent = new_entry(idx);
        we           = 1'b1;
        w_index      = IDX_W'(idx);
        w_entry      = ent;
        vppn_of[idx] = ent.vppn;
        asid_of[idx] = ent.asid;
    endtask

    task automatic drive_search();
        s0_valid = ($urandom_range(3) != 0);
        s0_query = pick_query();
        s1_valid = ($urandom_range(3) != 0);
        s1_query = pick_query();
    endtask

    task automatic clear_strobes();
        s0_valid = 1'b0;
        s1_valid = 1'b0;
        we       = 1'b0;
    endtask

    initial begin
        void'($urandom(28451));
        clk       = 1'b0;
        rst_n     = 1'b0;
        clear_strobes();
        s0_query  = '0;
        s1_query  = '0;
        w_index   = '0;
        w_entry   = '0;
        r_index   = '0;
        tb_errors = 0;
        tag_base  = TOP_W'($urandom);
        for (int i = 0; i < TLBNUM; i++) begin
            vppn_of[i] = '0;
            asid_of[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // empty table, every search misses
        for (int n = 0; n < 16; n++) begin
            clear_strobes();
            drive_search();
            r_index = IDX_W'($urandom);
            @(negedge clk);
        end

        for (int i = 0; i < TLBNUM; i++) begin
            clear_strobes();
            drive_write(i);
            r_index = IDX_W'($urandom);
            @(negedge clk);
        end

        clear_strobes();
        for (int n = 0; n < 64; n++) begin
            r_index = IDX_W'($urandom);
            @(negedge clk);
        end

        // mixed traffic on both ports with the odd rewrite
        for (int n = 0; n < 600; n++) begin
            clear_strobes();
            drive_search();
            if ($urandom_range(7) == 0) begin
                drive_write(int'($urandom_range(TLBNUM - 1)));
            end
            r_index = IDX_W'($urandom);
            @(negedge clk);
        end
        clear_strobes();

        wait_cycles = 0;
        while (chk_pending && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (chk_pending) begin
            tb_errors++;
            $display("timeout waiting for the checker to finish the last search");
        end

        $display("checks %0d, errors %0d", chk_checks, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/tlb_pkg.sv
hdl/tlb_storage.sv
hdl/tlb_search.sv
hdl/tlb.sv
tb/tlb_checker.sv
tb/tb_tlb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_tlb \
    -f build.f \
    -o tb_tlb_sim

./obj_dir/tb_tlb_sim | tee "$LOG"

if grep -qx "PASS: all tests" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
